//--- design/rv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared types and constants for the byte-serial RV32I subset core.
// Every RTL file and the testbench pull these in with a wildcard import.
// ~~~~~~~~~~~~~~~~~~~~
package rv_pkg;

  localparam int addr_w  = 16;            // external bus address width
  localparam int reg_num = 32;            // general purpose registers

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [7:0]        byte_t;
  typedef logic [31:0]       word_t;
  typedef logic [4:0]        reg_idx_t;

  localparam addr_t start_addr = 16'h0000;  // pc after reset

  // major opcodes
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  // funct3 for alu ops
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for branches and memory
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_sb  = 3'b000;
  localparam logic [2:0] f3_sw  = 3'b010;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
  } alu_op_t;

  typedef enum logic [1:0] {mem_byte_s, mem_byte_u, mem_word} mem_size_t;

endpackage

//--- design/bus_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shares the 8-bit memory bus between fetch and load/store.
// One byte per four-phase req/ack handshake, load/store has priority.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
module bus_arbiter import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  hold,
  input  logic  f_req,
  input  addr_t f_addr,
  output logic  f_ack,
  input  logic  m_req,
  input  addr_t m_addr,
  input  logic  m_we,
  input  byte_t m_wdata,
  output logic  m_ack,
  output byte_t rdata_q,
  output addr_t addr,
  output byte_t wdata,
  output logic  we,
  input  byte_t rdata
);
  typedef enum logic [1:0] {own_idle, own_fetch, own_mem} owner_t;

  owner_t owner;
  logic   f_xfer;
  logic   m_xfer;

  // byte cycle completes on the first free cycle of an unacked request
  assign f_xfer = !hold && owner == own_fetch && f_req && !f_ack;
  assign m_xfer = !hold && owner == own_mem && m_req && !m_ack;

  assign addr  = (owner == own_mem) ? m_addr : f_addr;
  assign wdata = m_wdata;
  assign we    = m_xfer && m_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      owner <= own_idle;
      f_ack <= 1'b0;
      m_ack <= 1'b0;
    end else if (!hold) begin
      case (owner)
        own_idle: begin
          if (m_req) owner <= own_mem;       // load/store wins a tie
          else if (f_req) owner <= own_fetch;
        end
        own_fetch: begin
          if (f_xfer) f_ack <= 1'b1;
          else if (f_ack && !f_req) begin
            f_ack <= 1'b0;                   // bus freed when ack falls
            owner <= own_idle;
          end
        end
        own_mem: begin
          if (m_xfer) m_ack <= 1'b1;
          else if (m_ack && !m_req) begin
            m_ack <= 1'b0;
            owner <= own_idle;
          end
        end
        default: owner <= own_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (f_xfer || m_xfer) rdata_q <= rdata;  // byte read in completing cycle
  end

  // requesters only raise req again once their ack has fallen
  a_f_req_rise: assert property (@(posedge clk) disable iff (rst) $rose(f_req) |-> !f_ack);
  a_m_req_rise: assert property (@(posedge clk) disable iff (rst) $rose(m_req) |-> !m_ack);

endmodule

//--- design/byte_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~
// Instruction fetch. A fetch_start pulse reads four bytes from pc
// upward and returns the word with a one-cycle instr_valid pulse.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
module byte_fetch import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  fetch_start,
  input  addr_t pc,
  output word_t instr,
  output logic  instr_valid,
  output logic  f_req,
  output addr_t f_addr,
  input  logic  f_ack,
  input  byte_t rdata_q
);
  logic       busy;
  logic [1:0] cnt;     // byte index 0..3
  addr_t      base;

  assign f_addr = base + addr_t'(cnt);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy        <= 1'b0;
      cnt         <= 2'd0;
      f_req       <= 1'b0;
      instr_valid <= 1'b0;
      base        <= start_addr;
    end else begin
      instr_valid <= 1'b0;
      if (!busy) begin
        if (fetch_start) begin
          busy  <= 1'b1;
          cnt   <= 2'd0;
          f_req <= 1'b1;
          base  <= pc;
        end
      end else if (f_req) begin
        if (f_ack) f_req <= 1'b0;        // byte taken, release req
      end else if (!f_ack) begin
        if (cnt == 2'd3) begin
          busy        <= 1'b0;
          instr_valid <= 1'b1;
        end else begin
          cnt   <= cnt + 2'd1;
          f_req <= 1'b1;
        end
      end
    end
  end

  // little endian, the first byte ends up in the low bits
  always_ff @(posedge clk) begin
    if (busy && f_req && f_ack) instr <= {rdata_q, instr[31:8]};
  end

endmodule

//--- design/load_store.sv
// ~~~~~~~~~~~~~~~~~~~~
// Load/store unit. Runs one byte handshake for LB/LBU/SB and four for
// LW/SW at rising addresses, low byte first. mem_done pulses at the end
// and mem_rdata holds the extended load result after it.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
module load_store import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      mem_start,
  input  addr_t     mem_addr,
  input  mem_size_t mem_size,
  input  logic      mem_write,
  input  word_t     mem_wdata,
  output logic      mem_done,
  output word_t     mem_rdata,
  output logic      m_req,
  output addr_t     m_addr,
  output logic      m_we,
  output byte_t     m_wdata,
  input  logic      m_ack,
  input  byte_t     rdata_q
);
  logic       busy;
  logic       write_q;
  logic [1:0] cnt;
  logic [1:0] last;    // index of final byte
  mem_size_t  size_q;
  addr_t      base;
  word_t      wdata_q;
  word_t      data_q;

  assign last    = (size_q == mem_word) ? 2'd3 : 2'd0;
  assign m_addr  = base + addr_t'(cnt);
  assign m_we    = write_q;
  assign m_wdata = wdata_q[8*cnt +: 8];

  always_comb begin
    case (size_q)
      mem_byte_s: mem_rdata = {{24{data_q[7]}}, data_q[7:0]};
      mem_byte_u: mem_rdata = {24'b0, data_q[7:0]};
      default:    mem_rdata = data_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      write_q  <= 1'b0;
      cnt      <= 2'd0;
      m_req    <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (!busy) begin
        if (mem_start) begin
          busy    <= 1'b1;
          write_q <= mem_write;
          cnt     <= 2'd0;
          m_req   <= 1'b1;
        end
      end else if (m_req) begin
        if (m_ack) m_req <= 1'b0;
      end else if (!m_ack) begin
        if (cnt == last) begin
          busy     <= 1'b0;
          mem_done <= 1'b1;
        end else begin
          cnt   <= cnt + 2'd1;
          m_req <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_start && !busy) begin
      base    <= mem_addr;
      size_q  <= mem_size;
      wdata_q <= mem_wdata;
    end
    if (busy && m_req && m_ack) data_q[8*cnt +: 8] <= rdata_q;
  end

  // core must wait for mem_done before the next access
  a_no_overlap: assert property (@(posedge clk) disable iff (rst) mem_start |-> !busy);

endmodule

//--- design/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file, two async read ports, one sync write port.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  reg_idx_t rd,
  input  logic     rd_we,
  input  word_t    rd_data
);
  word_t regs [reg_num];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_num; i++) regs[i] <= '0;
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;  // x0 stays zero
    end
  end

endmodule

//--- design/alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// Combinational ALU for the OP and OP-IMM groups.
// Shifts take the amount from the low 5 bits of alu_b.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
module alu import rv_pkg::*; (
  input  word_t   alu_a,
  input  word_t   alu_b,
  input  alu_op_t alu_op,
  output word_t   alu_y
);
  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = alu_b[4:0];
  assign lt_s  = $signed(alu_a) < $signed(alu_b);
  assign lt_u  = alu_a < alu_b;

  always_comb begin
    case (alu_op)
      alu_add:  alu_y = alu_a + alu_b;
      alu_sub:  alu_y = alu_a - alu_b;
      alu_and:  alu_y = alu_a & alu_b;
      alu_or:   alu_y = alu_a | alu_b;
      alu_xor:  alu_y = alu_a ^ alu_b;
      alu_slt:  alu_y = {31'b0, lt_s};
      alu_sltu: alu_y = {31'b0, lt_u};
      alu_sll:  alu_y = alu_a << shamt;
      alu_srl:  alu_y = alu_a >> shamt;
      alu_sra:  alu_y = $signed(alu_a) >>> shamt;  // sign fill
      default:  alu_y = '0;
    endcase
  end

endmodule

//--- design/exec_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Control core. Steps fetch, execute, memory and writeback one
// instruction at a time, decodes fields and immediates, drives the
// register file, ALU and load/store unit, and keeps the pc.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
module exec_core import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  output logic      fetch_start,
  output addr_t     pc,
  input  word_t     instr,
  input  logic      instr_valid,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_idx_t  rd,
  output logic      rd_we,
  output word_t     rd_data,
  output word_t     alu_a,
  output word_t     alu_b,
  output alu_op_t   alu_op,
  input  word_t     alu_y,
  output logic      mem_start,
  output addr_t     mem_addr,
  output mem_size_t mem_size,
  output logic      mem_write,
  output word_t     mem_wdata,
  input  logic      mem_done,
  input  word_t     mem_rdata
);
  typedef enum logic [2:0] {s_fetch, s_wait, s_exec, s_mem, s_wb} state_t;

  state_t     state;
  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i, imm_s, imm_b, imm_u;
  word_t      ea;
  logic       is_lui, is_opimm, is_op, is_load, is_store, taken;
  addr_t      pc_next;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  assign is_lui   = opcode == opc_lui;
  assign is_opimm = opcode == opc_op_imm;
  assign is_op    = opcode == opc_op;
  assign is_load  = opcode == opc_load &&
                    (funct3 == f3_lb || funct3 == f3_lbu || funct3 == f3_lw);
  assign is_store = opcode == opc_store && (funct3 == f3_sb || funct3 == f3_sw);
  assign taken    = opcode == opc_branch &&
                    ((funct3 == f3_beq && rs1_data == rs2_data) ||
                     (funct3 == f3_bne && rs1_data != rs2_data));
  assign pc_next  = taken ? pc + imm_b[addr_w-1:0] : pc + addr_t'(4);

  // alu operand and op select
  assign alu_a = rs1_data;
  assign alu_b = is_op ? rs2_data : imm_i;
  always_comb begin
    case (funct3)
      f3_add_sub: alu_op = (is_op && instr[30]) ? alu_sub : alu_add;
      f3_sll:     alu_op = alu_sll;
      f3_slt:     alu_op = alu_slt;
      f3_sltu:    alu_op = alu_sltu;
      f3_xor:     alu_op = alu_xor;
      f3_srl_sra: alu_op = instr[30] ? alu_sra : alu_srl;  // srai too
      f3_or:      alu_op = alu_or;
      default:    alu_op = alu_and;
    endcase
  end

  // memory request
  assign ea        = rs1_data + (is_store ? imm_s : imm_i);
  assign mem_addr  = ea[addr_w-1:0];
  assign mem_write = is_store;
  assign mem_wdata = rs2_data;
  assign mem_start = state == s_exec && (is_load || is_store);
  always_comb begin
    if (funct3 == f3_lw) mem_size = mem_word;  // sw shares this code
    else if (funct3 == f3_lbu) mem_size = mem_byte_u;
    else mem_size = mem_byte_s;
  end

  assign fetch_start = state == s_fetch;
  assign rd_we   = (state == s_exec && (is_lui || is_opimm || is_op)) || state == s_wb;
  assign rd_data = (state == s_wb) ? mem_rdata : (is_lui ? imm_u : alu_y);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_fetch;
      pc    <= start_addr;
    end else begin
      case (state)
        s_fetch: state <= s_wait;
        s_wait:  if (instr_valid) state <= s_exec;
        s_exec: begin
          if (is_load || is_store) begin
            state <= s_mem;
          end else begin
            pc    <= pc_next;         // unknown opcodes fall through here
            state <= s_fetch;
          end
        end
        s_mem: begin
          if (mem_done) begin
            if (is_store) begin
              pc    <= pc_next;
              state <= s_fetch;
            end else begin
              state <= s_wb;
            end
          end
        end
        s_wb: begin
          pc    <= pc_next;
          state <= s_fetch;
        end
        default: state <= s_fetch;
      endcase
    end
  end

endmodule

//--- design/retro_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Top level of the byte-bus RV32I subset core. Connect addr, wdata,
// we and rdata to a byte memory; hold stalls every bus cycle.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
module retro_top import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  hold,
  output addr_t addr,
  output byte_t wdata,
  output logic  we,
  input  byte_t rdata
);
  logic      fetch_start, instr_valid, rd_we, mem_start, mem_write, mem_done;
  logic      f_req, f_ack, m_req, m_we, m_ack;
  addr_t     pc, mem_addr, f_addr, m_addr;
  word_t     instr, rs1_data, rs2_data, rd_data, alu_a, alu_b, alu_y;
  word_t     mem_wdata, mem_rdata;
  reg_idx_t  rs1, rs2, rd;
  alu_op_t   alu_op;
  mem_size_t mem_size;
  byte_t     m_wdata, rdata_q;

  exec_core   core0  (.*);
  reg_file    regs0  (.*);
  alu         alu0   (.*);
  byte_fetch  fetch0 (.*);
  load_store  lsu0   (.*);
  bus_arbiter arb0   (.*);

endmodule

//--- dv/tb_programs.svh
// ~~~~~~~~~~~~~~~~~~~~
// Program words, data bytes and the expected bus writes for the core
// testbench. Included in the testbench module after the rv_pkg import.
// ~~~~~~~~~~~~~~~~~~~~

  localparam int    n_prog    = 36;
  localparam int    n_data    = 4;
  localparam int    n_writes  = 33;
  localparam addr_t data_base = 16'h0100;

  // placed little endian from 0x0000, x1 is the store base 0x200
  localparam word_t prog [n_prog] = '{
    32'h20000093, 32'hFFB00113,  // addi x1 = 0x200; addi x2 = -5
    32'h00700193, 32'h40218233,  // addi x3 = 7; sub x4 = x3 - x2
    32'h0040A023, 32'h80000337,  // sw x4 to 0x200; lui x6 = 0x80000000
    32'h403352B3, 32'h0050A223,  // sra x5 = x6 >>> x3; sw x5 to 0x204
    32'h0F014513, 32'h00451513,  // xori x10 = x2 ^ 0xf0; slli x10 by 4
    32'h00855513, 32'h7F357513,  // srli x10 by 8; andi x10 with 0x7f3
    32'h00C56513, 32'h00A0A423,  // ori x10 with 0xc; sw x10 to 0x208
    32'h10000603, 32'h10004683,  // lb x12 from 0x100; lbu x13 from 0x100
    32'h10002703, 32'h00C0A623,  // lw x14 from 0x100; sw x12 to 0x20c
    32'h00D0A823, 32'h00E0AA23,  // sw x13 to 0x210; sw x14 to 0x214
    32'h003123B3, 32'h00313433,  // slt x7 = x2 < x3; sltu x8 = x2 < x3
    32'h0070AC23, 32'h00808E23,  // sw x7 to 0x218; sb x8 to 0x21c
    32'h0EE00793, 32'h00318463,  // addi x15 = 0xee marker; beq x3 x3 +8 taken
    32'h02F08823, 32'h023088A3,  // sb x15 to 0x230 skipped; sb x3 to 0x231
    32'h00218463, 32'h02308923,  // beq x3 x2 +8 not taken; sb x3 to 0x232
    32'h00219463, 32'h02F089A3,  // bne x3 x2 +8 taken; sb x15 to 0x233 skipped
    32'h02308A23, 32'h00319463,  // sb x3 to 0x234; bne x3 x3 +8 not taken
    32'h02308AA3, 32'h00000063   // sb x3 to 0x235; beq x0 x0 0 spins
  };

  localparam byte_t data_bytes [n_data] = '{8'h80, 8'h12, 8'h34, 8'h56};

  // each entry is {address, byte} in bus order
  localparam logic [23:0] wr_table [n_writes] = '{
    24'h0200_0C, 24'h0201_00, 24'h0202_00, 24'h0203_00,  // 7 - (-5) = 12
    24'h0204_00, 24'h0205_00, 24'h0206_00, 24'h0207_FF,  // sign fill by 7
    24'h0208_FC, 24'h0209_07, 24'h020A_00, 24'h020B_00,  // immediate chain
    24'h020C_80, 24'h020D_FF, 24'h020E_FF, 24'h020F_FF,  // lb sign extends
    24'h0210_80, 24'h0211_00, 24'h0212_00, 24'h0213_00,  // lbu zero extends
    24'h0214_80, 24'h0215_12, 24'h0216_34, 24'h0217_56,  // lw data word
    24'h0218_01, 24'h0219_00, 24'h021A_00, 24'h021B_00,  // -5 < 7 signed
    24'h021C_00,                                         // unsigned compare false
    24'h0231_07, 24'h0232_07, 24'h0234_07, 24'h0235_07   // branch paths taken
  };

//--- dv/tb_retro.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for retro_top. Runs the program table twice, first with
// hold low and then with random hold, and compares every bus write
// in order against the expected-write table.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
module tb_retro import rv_pkg::*; ();

  `include "tb_programs.svh"

  localparam int n_runs       = 2;
  localparam int tail_cycles  = 100;   // idle time to catch stray writes
  localparam int limit_cycles = n_runs * (n_prog * 40 * 4 + tail_cycles + 5);

  logic   clk;
  logic   rst;
  logic   hold;
  addr_t  addr;
  byte_t  wdata;
  logic   we;
  byte_t  rdata;
  byte_t  mem [65536];
  integer seed;

  retro_top dut0 (
    .clk   (clk),
    .rst   (rst),
    .hold  (hold),
    .addr  (addr),
    .wdata (wdata),
    .we    (we),
    .rdata (rdata)
  );

  assign rdata = mem[addr];  // async read of the current address

  always #5 clk = ~clk;

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "testbench stopped on error");
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic load_memory();
    addr_t a;
    for (int i = 0; i < 65536; i++) begin
      a      = addr_t'(i);
      mem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;  // fill differs per address
    end
    for (int i = 0; i < n_prog; i++) begin
      for (int b = 0; b < 4; b++) begin
        a      = addr_t'(4 * i + b);
        mem[a] = prog[i][8*b +: 8];      // little endian
      end
    end
    for (int i = 0; i < n_data; i++) mem[data_base + addr_t'(i)] = data_bytes[i];
  endtask

  task automatic run_program(input logic use_hold);
    int    wr_idx;
    int    fetch_seen;
    int    tail;
    addr_t last_addr;
    wr_idx     = 0;
    fetch_seen = 0;
    tail       = tail_cycles;
    last_addr  = '0;
    load_memory();
    rst  = 1'b1;
    hold = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    while (tail > 0) begin
      @(negedge clk);
      if (hold && we) stop_with_error("we is high while hold is high");
      // first four distinct addresses are the first fetch bytes
      if (fetch_seen < 4 && (fetch_seen == 0 || addr != last_addr)) begin
        if (we) stop_with_error("bus write during the first instruction fetch");
        check_addr("addr", addr, addr_t'(fetch_seen));
        last_addr  = addr;
        fetch_seen = fetch_seen + 1;
      end
      if (we) begin
        if (wr_idx >= n_writes) stop_with_error("bus write after the last expected write");
        check_addr("addr", addr, wr_table[wr_idx][23:8]);
        check_byte("wdata", wdata, wr_table[wr_idx][7:0]);
        mem[addr] = wdata;
        wr_idx    = wr_idx + 1;
      end
      if (wr_idx == n_writes) tail = tail - 1;
      @(posedge clk);
      #1 hold = use_hold && (($random(seed) & 3) == 0);  // hold about a quarter of cycles
    end
  endtask

  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    hold = 1'b0;
    seed = 34;
    run_program(1'b0);
    run_program(1'b1);
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    #(limit_cycles * 10);
    $display("timeout after %0d cycles before the write table completed", limit_cycles);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sim.f
+incdir+dv
design/rv_pkg.sv
design/bus_arbiter.sv
design/byte_fetch.sv
design/load_store.sv
design/reg_file.sv
design/alu.sv
design/exec_core.sv
design/retro_top.sv
dv/tb_retro.sv

//--- run.sh
#!/bin/sh
# Compile and run the retro_top testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f sim.f --top-module tb_retro -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_retro
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi
exit 0
